// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath widths
    localparam int XLEN    = 32;
    localparam int ORDER_W = 64;

    // line and memory beat geometry
    localparam int LINE_W         = 256;
    localparam int BEAT_W         = 64;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int WORDS_PER_LINE = LINE_W / XLEN;
    localparam int LINE_OFF_W     = $clog2(LINE_W / 8);

    // index widths derived from the geometry
    localparam int BEAT_IDX_W = $clog2(BEATS_PER_LINE);
    localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);

    // boot address
    localparam logic [XLEN-1:0] RESET_PC = 32'haaaaa000;

    // instruction queue sizing
    localparam int IQ_DEPTH = 16;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W = IQ_PTR_W + 1;

    // completed line fill, valid is a single-cycle pulse
    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] line;
    } line_fill_t;

    // queue payload, also the entry handed to decode
    typedef struct packed {
        logic [ORDER_W-1:0] order;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    inst;
    } fetch_entry_t;

    // redirect request from the back end
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: verilog/burst_line_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module burst_line_assembler
import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_rvalid_i,
    input  logic              bmem_read_i,
    input  logic              discard_i,

    output line_fill_t        fill_o
);

    logic [BEAT_IDX_W-1:0] beat_cnt_q;
    logic [LINE_W-1:0]     line_q;
    logic                  fill_valid_q;
    logic                  expect_q;
    logic                  drop_q;
    logic                  last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt_q == BEAT_IDX_W'(BEATS_PER_LINE - 1));

    // lower beat lands in the lower bits of the line
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i && !(drop_q || discard_i)) begin
            line_q[beat_cnt_q * BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            fill_valid_q <= 1'b0;
            expect_q     <= 1'b0;
            drop_q       <= 1'b0;
        end else begin
            // end of every burst is marked, dropped data included
            fill_valid_q <= last_beat;
            if (bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            if (bmem_read_i) begin
                expect_q <= 1'b1;
            end else if (last_beat) begin
                expect_q <= 1'b0;
            end
            // stale burst after a redirect, stop writing it
            if (last_beat) begin
                drop_q <= 1'b0;
            end else if (discard_i && expect_q) begin
                drop_q <= 1'b1;
            end
        end
    end

    assign fill_o = '{valid: fill_valid_q, line: line_q};

    // beats only come back for a line that was asked for
    beat_needs_request: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> expect_q);

endmodule

`default_nettype wire

// File: verilog/fetch_control.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_control
import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    // memory request side
    input  logic            bmem_ready_i,
    output logic [XLEN-1:0] bmem_addr_o,
    output logic            bmem_read_o,

    // line fill from the assembler
    input  line_fill_t      fill_i,
    output logic            discard_o,

    // queue push side
    input  logic            full_i,
    output logic            push_o,
    output fetch_entry_t    push_entry_o,

    input  redirect_t       redirect_i
);

    logic [XLEN-1:0]            pc_q;
    logic [ORDER_W-1:0]         order_q;

    // one-line buffer
    logic [LINE_W-1:0]          buf_line_q;
    logic [XLEN-LINE_OFF_W-1:0] buf_tag_q;
    logic                       buf_valid_q;

    logic                       pending_q;
    logic                       discard_q;
    logic                       started_q;

    logic [WORD_IDX_W-1:0]      word_idx;
    logic                       hit;

    assign word_idx = pc_q[LINE_OFF_W-1 -: WORD_IDX_W];
    assign hit      = buf_valid_q && (buf_tag_q == pc_q[XLEN-1:LINE_OFF_W]);

    // one entry per cycle while the line buffer covers pc
    assign push_o       = hit && !full_i && !redirect_i.valid;
    assign push_entry_o = '{
        order: order_q,
        pc:    pc_q,
        inst:  buf_line_q[word_idx * XLEN +: XLEN]
    };

    // line-aligned request with at most one in flight
    assign bmem_addr_o = {pc_q[XLEN-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    assign bmem_read_o = started_q && !hit && !pending_q && bmem_ready_i && !redirect_i.valid;

    assign discard_o = discard_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= RESET_PC;
            order_q     <= '0;
            buf_valid_q <= 1'b0;
            pending_q   <= 1'b0;
            discard_q   <= 1'b0;
            started_q   <= 1'b0;
        end else begin
            // keeps the first cycle after reset quiet
            started_q <= 1'b1;

            if (bmem_read_o) begin
                pending_q <= 1'b1;
            end else if (fill_i.valid) begin
                pending_q <= 1'b0;
            end

            // fill still in flight at a redirect belongs to the old path
            if (fill_i.valid) begin
                discard_q <= 1'b0;
            end else if (redirect_i.valid && pending_q) begin
                discard_q <= 1'b1;
            end

            if (redirect_i.valid) begin
                // order keeps counting across redirects
                pc_q        <= redirect_i.pc;
                buf_valid_q <= 1'b0;
            end else begin
                if (fill_i.valid && !discard_q) begin
                    buf_valid_q <= 1'b1;
                end
                if (push_o) begin
                    pc_q    <= pc_q + XLEN'(4);
                    order_q <= order_q + ORDER_W'(1);
                end
            end
        end
    end

    // pc does not move while a fill is pending, so its tag names the line
    always_ff @(posedge clk) begin
        if (fill_i.valid && !discard_q) begin
            buf_line_q <= fill_i.line;
            buf_tag_q  <= pc_q[XLEN-1:LINE_OFF_W]; 
        end
    end

    // fills only come back for the request in flight
    fill_needs_request: assert property (@(posedge clk) disable iff (rst)
        fill_i.valid |-> pending_q);

endmodule

`default_nettype wire

// File: verilog/instr_queue.sv
`timescale 1ns/1ns
`default_nettype none

module instr_queue
import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         push_i,
    input  fetch_entry_t push_entry_i,
    output logic         full_o,

    // decode side
    input  logic         hold_i,
    input  logic         flush_i,
    output logic         valid_o,
    output fetch_entry_t head_o
);

    fetch_entry_t          entries_q [IQ_DEPTH];
    logic [IQ_PTR_W-1:0]   rd_ptr_q;
    logic [IQ_PTR_W-1:0]   wr_ptr_q;
    logic [IQ_CNT_W-1:0]   count_q;
    logic                  push_ok;
    logic                  pop;

    assign full_o = (count_q == IQ_CNT_W'(IQ_DEPTH));

    // head goes to decode in the same cycle it is offered
    assign valid_o = (count_q != '0) && !hold_i && !flush_i;
    assign head_o  = entries_q[rd_ptr_q];

    assign pop     = valid_o;
    assign push_ok = push_i && !full_o && !flush_i;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            entries_q[wr_ptr_q] <= push_entry_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // fetch must respect the full flag
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push_i |-> !full_o);

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // burst memory port, read only
    output logic [XLEN-1:0]   bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    // decode side
    input  logic              decode_stall_i,
    input  logic              redirect_i,
    input  logic [XLEN-1:0]   redirect_pc_i,
    output logic              fetch_valid_o,
    output fetch_entry_t      fetch_entry_o
);

    redirect_t    redirect;
    line_fill_t   fill;
    logic         discard;
    logic         push;
    fetch_entry_t push_entry;
    logic         queue_full;

    assign redirect = '{valid: redirect_i, pc: redirect_pc_i};

    burst_line_assembler line_asm_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_read_i   (bmem_read_o),
        .discard_i     (discard),
        .fill_o        (fill)
    );

    fetch_control fetch_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .fill_i       (fill),
        .discard_o    (discard),
        .full_i       (queue_full),
        .push_o       (push),
        .push_entry_o (push_entry),
        .redirect_i   (redirect)
    );

    // only the queue is flushed by a redirect
    instr_queue instr_queue_i (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .push_entry_i (push_entry),
        .full_o       (queue_full),
        .hold_i       (decode_stall_i),
        .flush_i      (redirect.valid),
        .valid_o      (fetch_valid_o),
        .head_o       (fetch_entry_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD_NS  = 100;
    localparam int RST_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release 10 ns after an edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/bmem_model.sv
`timescale 1ns/1ns
`default_nettype none

module bmem_model
import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   bmem_addr_i,
    input  logic              bmem_read_i,
    output logic              bmem_ready_o,
    output logic [BEAT_W-1:0] bmem_rdata_o,
    output logic              bmem_rvalid_o
);

    localparam logic [XLEN-1:0] MEM_KEY = 32'h5a5a5a5a;

    logic [31:0]       lfsr_q = 32'h9cc6;
    logic              busy;
    logic              gap_next;
    int                wait_cnt;
    int                beat_idx;
    logic [XLEN-1:0]   line_addr;
    logic [XLEN-1:0]   beat_addr;
    logic              rvalid_n;
    logic [BEAT_W-1:0] rdata_n;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val    = (val << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        return val;
    endfunction

    // memory content
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        return addr ^ MEM_KEY;
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
    end

    always @(posedge clk) begin
        rvalid_n = 1'b0;
        rdata_n  = '0;
        if (rst) begin
            busy     = 1'b0;
            gap_next = 1'b0;
            bmem_ready_o <= #10 1'b0;
        end else begin
            // first beat 1 to 6 cycles after the request
            if (bmem_read_i) begin
                busy      = 1'b1;
                line_addr = bmem_addr_i;
                beat_idx  = 0;
                gap_next  = 1'b0;
                wait_cnt  = take_bits(3) % 6;
            end
            if (busy) begin
                if (wait_cnt != 0) begin
                    wait_cnt--;
                end else if (gap_next) begin
                    gap_next = 1'b0;
                end else begin
                    beat_addr = line_addr + XLEN'(8 * beat_idx);
                    rvalid_n  = 1'b1;
                    rdata_n   = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
                    beat_idx++;
                    busy      = (beat_idx < BEATS_PER_LINE);
                    gap_next  = (take_bits(1) != 0);
                end
            end
            // ready low about one cycle in four
            bmem_ready_o <= #10 (take_bits(2) != 0);
        end
        bmem_rvalid_o <= #10 rvalid_n;
        bmem_rdata_o  <= #10 rdata_n;
    end

endmodule

`default_nettype wire

// File: tb/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
import fetch_pkg::*;
();

    localparam logic [XLEN-1:0] MEM_KEY     = 32'h5a5a5a5a;
    localparam int              TOTAL_INSTR = 64 + 32 + 24 + 16 + 16;
    localparam int              TIMEOUT_CYC = TOTAL_INSTR * 40 + 200;

    logic clk, rst;
    logic [XLEN-1:0]   bmem_addr;
    logic              bmem_read, bmem_ready, bmem_rvalid;
    logic [BEAT_W-1:0] bmem_rdata;
    logic              decode_stall, redirect, fetch_valid;
    logic [XLEN-1:0]   redirect_pc;
    fetch_entry_t      fetch_entry;

    // scoreboard state updated at every rising edge
    logic               rst_d, chain_valid, seen_any, expect_target, req_seq;
    logic [XLEN-1:0]    target_pc, last_pc, last_req_addr;
    logic [ORDER_W-1:0] last_order;
    int beats_left, delivered, req_count;
    int err_count, mark, tests_run, tests_failed;

    tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

    bmem_model bmem_i (
        .clk(clk), .rst(rst), .bmem_addr_i(bmem_addr), .bmem_read_i(bmem_read),
        .bmem_ready_o(bmem_ready), .bmem_rdata_o(bmem_rdata), .bmem_rvalid_o(bmem_rvalid)
    );

    fetch_top fetch_top_i (
        .clk(clk), .rst(rst), .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read),
        .bmem_ready_i(bmem_ready), .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid),
        .decode_stall_i(decode_stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .fetch_valid_o(fetch_valid), .fetch_entry_o(fetch_entry)
    );

    always @(posedge clk) begin
        rst_d <= rst;
        if (rst) begin
            {chain_valid, seen_any, expect_target, req_seq} <= '0;
            beats_left <= 0;
            delivered  <= 0;
            req_count  <= 0;
        end else begin
            beats_left <= beats_left - int'(bmem_rvalid) + (bmem_read ? BEATS_PER_LINE : 0);
            if (bmem_read) begin
                req_count     <= req_count + 1;
                req_seq       <= 1'b1;
                last_req_addr <= bmem_addr;
            end
            if (fetch_valid) begin
                delivered <= delivered + 1;
            end
            // a redirect breaks both the pc chain and the request stride
            if (redirect) begin
                {chain_valid, req_seq, expect_target} <= 3'b001;
                target_pc <= redirect_pc;
            end else if (fetch_valid) begin
                {chain_valid, seen_any, expect_target} <= 3'b110;
                last_pc    <= fetch_entry.pc;
                last_order <= fetch_entry.order;
            end
        end
    end

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_count++;
        $display("ERR %0t %s got %0h exp %0h", $time, sig, got, exp);
    endtask

    reset_no_read: assert property (@(posedge clk) (rst || rst_d) |-> !bmem_read)
        else report_mismatch("bmem_read_o", $sampled(bmem_read), 0);
    // queue count is unknown before the first reset edge
    reset_no_valid: assert property (@(posedge clk) rst_d |-> !fetch_valid)
        else report_mismatch("fetch_valid_o", $sampled(fetch_valid), 0);
    first_req_addr: assert property (@(posedge clk) disable iff (rst)
        bmem_read && req_count == 0 |-> bmem_addr == (RESET_PC & ~32'h1f))
        else report_mismatch("bmem_addr_o", $sampled(bmem_addr), RESET_PC & ~32'h1f);
    req_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> bmem_addr[LINE_OFF_W-1:0] == '0)
        else report_mismatch("bmem_addr_o", $sampled(bmem_addr), $sampled(bmem_addr) & ~32'h1f);
    req_after_beats: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> beats_left == 0)
        else report_mismatch("beats outstanding at bmem_read_o", $sampled(beats_left), 0);
    req_stride: assert property (@(posedge clk) disable iff (rst)
        bmem_read && req_seq |-> bmem_addr == last_req_addr + 32'd32)
        else report_mismatch("bmem_addr_o", $sampled(bmem_addr), $sampled(last_req_addr) + 32);
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        decode_stall |-> !fetch_valid)
        else report_mismatch("fetch_valid_o", $sampled(fetch_valid), 0);
    entry_inst: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_entry.inst == (fetch_entry.pc ^ MEM_KEY))
        else report_mismatch("fetch_entry_o.inst", $sampled(fetch_entry.inst),
                             $sampled(fetch_entry.pc) ^ MEM_KEY);
    entry_pc_step: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && chain_valid |-> fetch_entry.pc == last_pc + 32'd4)
        else report_mismatch("fetch_entry_o.pc", $sampled(fetch_entry.pc), $sampled(last_pc) + 4);
    entry_order_step: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && chain_valid |-> fetch_entry.order == last_order + 64'd1)
        else report_mismatch("fetch_entry_o.order", $sampled(fetch_entry.order),
                             $sampled(last_order) + 1);
    order_rising: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && seen_any |-> fetch_entry.order > last_order)
        else report_mismatch("fetch_entry_o.order", $sampled(fetch_entry.order),
                             $sampled(last_order) + 1);
    redirect_target: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && expect_target |-> fetch_entry.pc == target_pc)
        else report_mismatch("fetch_entry_o.pc", $sampled(fetch_entry.pc), $sampled(target_pc));

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic wait_entries(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(posedge clk);
        #10;
    endtask

    task automatic wait_next_request();
        int start;
        start = req_count;
        while (req_count == start) @(posedge clk);
        #10;
    endtask

    task automatic pulse_redirect(input logic [XLEN-1:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        step_cycles(1);
        redirect    = 1'b0;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (err_count != mark) begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - mark);
        end else begin
            $display("test %s: ok", name);
        end
        mark = err_count;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d entries delivered", cycles, delivered);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        decode_stall = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        {err_count, mark, tests_run, tests_failed} = '0;
        wait (rst == 1'b0);
        wait_next_request();
        close_test("reset");
        wait_entries(64);
        close_test("sequential stream");
        wait_entries(32);
        close_test("line requests");
        // queue fills and fetch stalls behind it
        decode_stall = 1'b1;
        step_cycles(60);
        decode_stall = 1'b0;
        wait_entries(24);
        close_test("back-pressure");
        // quiet front end before the redirect
        decode_stall = 1'b1;
        step_cycles(80);
        while (beats_left != 0) step_cycles(1);
        step_cycles(3);
        decode_stall = 1'b0;
        pulse_redirect(32'h1000_0104);
        wait_entries(16);
        close_test("redirect idle");
        wait_next_request();
        pulse_redirect(32'h2345_6788);
        wait_entries(16);
        close_test("redirect with fill outstanding");
        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/fetch_pkg.sv
verilog/burst_line_assembler.sv
verilog/fetch_control.sv
verilog/instr_queue.sv
verilog/fetch_top.sv
tb/tb_clock_gen.sv
tb/bmem_model.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/burst_line_assembler.sv
      - verilog/fetch_control.sv
      - verilog/instr_queue.sv
      - verilog/fetch_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/bmem_model.sv
      - tb/fetch_tb.sv
